/* rtl/blob_pkg.sv */
`default_nettype none

package blob_pkg;

    // one colour sample from the camera stream
    localparam int COLOR_WIDTH = 8;
    typedef logic [COLOR_WIDTH-1:0] channel_t;

    // coordinate widths cover lines up to 1280 pixels and frames up to 720 lines
    localparam int X_WIDTH = 11;
    localparam int Y_WIDTH = 10;
    typedef logic [X_WIDTH-1:0] x_coord_t;
    typedef logic [Y_WIDTH-1:0] y_coord_t;

    // hit counter wide enough for every pixel of a 1280x720 frame
    localparam int COUNT_WIDTH = 20;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // coordinate sum over a full frame of hits
    // worst case is 1279 * 921600, which still fits in 32 bits
    localparam int SUM_WIDTH = 32;
    typedef logic [SUM_WIDTH-1:0] sum_t;

    // default frame geometry, matches the downscaled camera buffer
    localparam int DEFAULT_H_PIXELS = 320;
    localparam int DEFAULT_V_LINES = 180;

endpackage

`default_nettype wire

/* rtl/pixel_position.sv */
`default_nettype none

module pixel_position #(
    parameter int H_PIXELS = blob_pkg::DEFAULT_H_PIXELS,
    parameter int V_LINES = blob_pkg::DEFAULT_V_LINES
) (
    input  logic               clk_pixel,
    input  logic               recent_reset,
    input  logic               pix_valid,
    input  logic               pix_sof,
    input  logic               pix_eol,
    input  logic               pix_eof,
    input  blob_pkg::channel_t pix_red,
    input  blob_pkg::channel_t pix_blue,
    output logic               pos_valid,
    output logic               pos_eof,
    output blob_pkg::x_coord_t pos_x,
    output blob_pkg::y_coord_t pos_y,
    output blob_pkg::channel_t pos_red,
    output blob_pkg::channel_t pos_blue
);
    import blob_pkg::*;

    // position of the next pixel expected on the stream
    x_coord_t col;
    y_coord_t row;

    // coordinates of the pixel currently on the input
    x_coord_t cur_x;
    y_coord_t cur_y;

    // sof forces the origin, so a frame never inherits stale counters
    assign cur_x = pix_sof ? '0 : col;
    assign cur_y = pix_sof ? '0 : row;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            col <= '0;
            row <= '0;
        end else if (pix_valid) begin
            if (pix_eof) begin
                col <= '0;
                row <= '0;
            end else if (pix_eol) begin
                // wrap to the start of the next line
                col <= '0;
                row <= cur_y + 1'b1;
            end else begin
                col <= cur_x + 1'b1;
                row <= cur_y;
            end
        end
    end

    // stage strobes
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            pos_valid <= 1'b0;
            pos_eof   <= 1'b0;
        end else begin
            pos_valid <= pix_valid;
            pos_eof   <= pix_valid && pix_eof;
        end
    end

    // pixel payload travels with its coordinates
    always_ff @(posedge clk_pixel) begin
        if (pix_valid) begin
            pos_x    <= cur_x;
            pos_y    <= cur_y;
            pos_red  <= pix_red;
            pos_blue <= pix_blue;
        end
    end

    // a line longer than H_PIXELS means the source lost an eol
    assert property (@(posedge clk_pixel) disable iff (recent_reset)
        pix_valid && pix_eol |-> int'(cur_x) < H_PIXELS)
        else $error("eol beyond the last column");

    // eof has to land on the very last pixel of the frame
    assert property (@(posedge clk_pixel) disable iff (recent_reset)
        pix_valid && pix_eof |-> int'(cur_x) == H_PIXELS - 1 && int'(cur_y) == V_LINES - 1)
        else $error("eof not on the last pixel of the frame");

endmodule

`default_nettype wire

/* rtl/color_mask.sv */
`default_nettype none

module color_mask (
    input  logic               clk_pixel,
    input  logic               recent_reset,
    input  logic               pos_valid,
    input  logic               pos_eof,
    input  blob_pkg::x_coord_t pos_x,
    input  blob_pkg::y_coord_t pos_y,
    input  blob_pkg::channel_t pos_red,
    input  blob_pkg::channel_t pos_blue,
    input  blob_pkg::channel_t lower_bound,
    input  blob_pkg::channel_t upper_bound,
    output logic               hit_valid,
    output logic               hit_eof,
    output logic               red_hit,
    output logic               blue_hit,
    output blob_pkg::x_coord_t hit_x,
    output blob_pkg::y_coord_t hit_y
);

    // both ends of the window count as a hit
    logic red_in_window;
    logic blue_in_window;

    assign red_in_window  = (pos_red >= lower_bound) && (pos_red <= upper_bound);
    assign blue_in_window = (pos_blue >= lower_bound) && (pos_blue <= upper_bound);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hit_valid <= 1'b0;
            hit_eof   <= 1'b0;
        end else begin
            hit_valid <= pos_valid;
            hit_eof   <= pos_valid && pos_eof;
        end
    end

    // mask bits and coordinates stay aligned with hit_valid
    always_ff @(posedge clk_pixel) begin
        if (pos_valid) begin
            red_hit  <= red_in_window;
            blue_hit <= blue_in_window;
            hit_x    <= pos_x;
            hit_y    <= pos_y;
        end
    end

    // an inverted window silently masks every pixel of the frame
    assert property (@(posedge clk_pixel) disable iff (recent_reset)
        pos_valid |-> lower_bound <= upper_bound)
        else $error("threshold window inverted while pixels flow");

endmodule

`default_nettype wire

/* rtl/seq_divider.sv */
`default_nettype none

module seq_divider #(
    parameter int DIVIDEND_WIDTH = 32,
    parameter int DIVISOR_WIDTH = 20
) (
    input  logic                      clk_pixel,
    input  logic                      recent_reset,
    input  logic                      start,
    input  logic [DIVIDEND_WIDTH-1:0] dividend,
    input  logic [DIVISOR_WIDTH-1:0]  divisor,
    output logic                      busy,
    output logic                      done,
    output logic [DIVIDEND_WIDTH-1:0] quotient
);

    localparam int StepWidth = $clog2(DIVIDEND_WIDTH + 1);

    // quotient bits still to produce
    logic [StepWidth-1:0] steps_left;

    // dividend bits shift out at the top, quotient bits shift in at the bottom
    logic [DIVIDEND_WIDTH-1:0] work;
    logic [DIVISOR_WIDTH-1:0]  rem;
    logic [DIVISOR_WIDTH-1:0]  dvsr;

    // partial remainder with the next dividend bit appended
    logic [DIVISOR_WIDTH:0] trial;
    logic [DIVISOR_WIDTH:0] diff;
    logic                   fits;

    assign trial = {rem, work[DIVIDEND_WIDTH-1]};
    assign diff  = trial - {1'b0, dvsr};
    assign fits  = trial >= {1'b0, dvsr};

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            busy       <= 1'b0;
            done       <= 1'b0;
            steps_left <= '0;
            quotient   <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy       <= 1'b1;
                steps_left <= StepWidth'(DIVIDEND_WIDTH);
            end else if (busy) begin
                if (steps_left != '0) begin
                    steps_left <= steps_left - 1'b1;
                end else begin
                    // extra finishing cycle publishes the result
                    busy     <= 1'b0;
                    done     <= 1'b1;
                    // a zero divisor would leave all ones, report zero instead
                    quotient <= (dvsr == '0) ? '0 : work;
                end
            end
        end
    end

    // shift-subtract datapath
    always_ff @(posedge clk_pixel) begin
        if (start) begin
            work <= dividend;
            rem  <= '0;
            dvsr <= divisor;
        end else if (busy && steps_left != '0) begin
            work <= {work[DIVIDEND_WIDTH-2:0], fits};
            // restore when the divisor does not fit
            rem  <= fits ? diff[DIVISOR_WIDTH-1:0] : trial[DIVISOR_WIDTH-1:0];
        end
    end

    // a restart in flight would corrupt the running division
    assert property (@(posedge clk_pixel) disable iff (recent_reset)
        start |-> !busy)
        else $error("divider started while busy");

endmodule

`default_nettype wire

/* rtl/centroid_accum.sv */
`default_nettype none

module centroid_accum #(
    parameter int H_PIXELS = blob_pkg::DEFAULT_H_PIXELS,
    parameter int V_LINES = blob_pkg::DEFAULT_V_LINES
) (
    input  logic               clk_pixel,
    input  logic               recent_reset,
    input  logic               hit_valid,
    input  logic               hit_eof,
    input  logic               red_hit,
    input  logic               blue_hit,
    input  blob_pkg::x_coord_t hit_x,
    input  blob_pkg::y_coord_t hit_y,
    output blob_pkg::x_coord_t blob_x,
    output blob_pkg::y_coord_t blob_y,
    output blob_pkg::count_t   red_count,
    output blob_pkg::count_t   blue_count,
    output logic               blob_found,
    output logic               result_valid
);
    import blob_pkg::*;

    // running totals for the frame in progress
    sum_t   sum_x;
    sum_t   sum_y;
    count_t cnt_red;
    count_t cnt_blue;

    // running totals including the pixel on the input
    sum_t   next_sum_x;
    sum_t   next_sum_y;
    count_t next_red;
    count_t next_blue;

    // frozen totals of the last finished frame
    sum_t   tot_x;
    sum_t   tot_y;
    count_t tot_red;
    count_t tot_blue;

    // divider handshake
    logic div_start;
    logic div_busy_x;
    logic div_busy_y;
    logic div_done_x;
    logic div_done_y;
    sum_t quot_x;
    sum_t quot_y;

    always_comb begin
        next_sum_x = sum_x;
        next_sum_y = sum_y;
        next_red   = cnt_red;
        next_blue  = cnt_blue;
        // only red hits feed the centroid
        if (hit_valid && red_hit) begin
            next_sum_x = sum_x + sum_t'(hit_x);
            next_sum_y = sum_y + sum_t'(hit_y);
            next_red   = cnt_red + 1'b1;
        end
        if (hit_valid && blue_hit) begin
            next_blue = cnt_blue + 1'b1;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset || (hit_valid && hit_eof)) begin
            // eof restarts accumulation for the next frame
            sum_x    <= '0;
            sum_y    <= '0;
            cnt_red  <= '0;
            cnt_blue <= '0;
        end else begin
            sum_x    <= next_sum_x;
            sum_y    <= next_sum_y;
            cnt_red  <= next_red;
            cnt_blue <= next_blue;
        end
    end

    // totals hold through the division
    always_ff @(posedge clk_pixel) begin
        if (hit_valid && hit_eof) begin
            tot_x    <= next_sum_x;
            tot_y    <= next_sum_y;
            tot_red  <= next_red;
            tot_blue <= next_blue;
        end
    end

    // kick both dividers one cycle after the totals are frozen
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            div_start <= 1'b0;
        end else begin
            div_start <= hit_valid && hit_eof;
        end
    end

    seq_divider #(
        .DIVIDEND_WIDTH(SUM_WIDTH),
        .DIVISOR_WIDTH(COUNT_WIDTH)
    ) u_div_x (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .start(div_start),
        .dividend(tot_x),
        .divisor(tot_red),
        .busy(div_busy_x),
        .done(div_done_x),
        .quotient(quot_x)
    );

    seq_divider #(
        .DIVIDEND_WIDTH(SUM_WIDTH),
        .DIVISOR_WIDTH(COUNT_WIDTH)
    ) u_div_y (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .start(div_start),
        .dividend(tot_y),
        .divisor(tot_red),
        .busy(div_busy_y),
        .done(div_done_y),
        .quotient(quot_y)
    );

    // results hold until the next frame completes
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            blob_x       <= '0;
            blob_y       <= '0;
            red_count    <= '0;
            blue_count   <= '0;
            blob_found   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (div_done_x && div_done_y) begin
                // a mean coordinate always fits the coordinate width
                blob_x       <= quot_x[X_WIDTH-1:0];
                blob_y       <= quot_y[Y_WIDTH-1:0];
                red_count    <= tot_red;
                blue_count   <= tot_blue;
                blob_found   <= tot_red != '0;
                result_valid <= 1'b1;
            end
        end
    end

    // no back-pressure, so a frame must not end while a division is pending
    assert property (@(posedge clk_pixel) disable iff (recent_reset)
        hit_valid && hit_eof |-> !(div_start || div_busy_x || div_busy_y))
        else $error("frame ended while the dividers were busy");

    // mean of in-frame coordinates stays inside the frame
    assert property (@(posedge clk_pixel) disable iff (recent_reset)
        div_done_x |-> quot_x < H_PIXELS && quot_y < V_LINES)
        else $error("centroid outside the frame");

endmodule

`default_nettype wire

/* rtl/blob_tracker_top.sv */
`default_nettype none

module blob_tracker_top #(
    parameter int H_PIXELS = blob_pkg::DEFAULT_H_PIXELS,
    parameter int V_LINES = blob_pkg::DEFAULT_V_LINES
) (
    input  logic               clk_pixel,
    input  logic               recent_reset,
    // pixel stream
    input  logic               pix_valid,
    input  blob_pkg::channel_t pix_red,
    input  blob_pkg::channel_t pix_blue,
    input  logic               pix_sof,
    input  logic               pix_eol,
    input  logic               pix_eof,
    // shared threshold window for red and blue
    input  blob_pkg::channel_t lower_bound,
    input  blob_pkg::channel_t upper_bound,
    // per-frame results
    output blob_pkg::x_coord_t blob_x,
    output blob_pkg::y_coord_t blob_y,
    output blob_pkg::count_t   red_count,
    output blob_pkg::count_t   blue_count,
    output logic               blob_found,
    output logic               result_valid
);
    import blob_pkg::*;

    // position stage outputs
    logic     pos_valid;
    logic     pos_eof;
    x_coord_t pos_x;
    y_coord_t pos_y;
    channel_t pos_red;
    channel_t pos_blue;

    // mask stage outputs
    logic     hit_valid;
    logic     hit_eof;
    logic     red_hit;
    logic     blue_hit;
    x_coord_t hit_x;
    y_coord_t hit_y;

    pixel_position #(
        .H_PIXELS(H_PIXELS),
        .V_LINES(V_LINES)
    ) u_pixel_position (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .pix_valid(pix_valid),
        .pix_sof(pix_sof),
        .pix_eol(pix_eol),
        .pix_eof(pix_eof),
        .pix_red(pix_red),
        .pix_blue(pix_blue),
        .pos_valid(pos_valid),
        .pos_eof(pos_eof),
        .pos_x(pos_x),
        .pos_y(pos_y),
        .pos_red(pos_red),
        .pos_blue(pos_blue)
    );

    // red and blue share one window, as the two thresholders did
    color_mask u_color_mask (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .pos_valid(pos_valid),
        .pos_eof(pos_eof),
        .pos_x(pos_x),
        .pos_y(pos_y),
        .pos_red(pos_red),
        .pos_blue(pos_blue),
        .lower_bound(lower_bound),
        .upper_bound(upper_bound),
        .hit_valid(hit_valid),
        .hit_eof(hit_eof),
        .red_hit(red_hit),
        .blue_hit(blue_hit),
        .hit_x(hit_x),
        .hit_y(hit_y)
    );

    centroid_accum #(
        .H_PIXELS(H_PIXELS),
        .V_LINES(V_LINES)
    ) u_centroid_accum (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .hit_valid(hit_valid),
        .hit_eof(hit_eof),
        .red_hit(red_hit),
        .blue_hit(blue_hit),
        .hit_x(hit_x),
        .hit_y(hit_y),
        .blob_x(blob_x),
        .blob_y(blob_y),
        .red_count(red_count),
        .blue_count(blue_count),
        .blob_found(blob_found),
        .result_valid(result_valid)
    );

endmodule

`default_nettype wire

/* verification/tb_frame_table.svh */
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

// one frame scenario per row
// rectangles are inclusive corners x0,y0 .. x1,y1; x0 > x1 leaves the rectangle empty
// pixels outside a rectangle carry the background value on that channel
typedef struct packed {
    logic [7:0] red_x0;
    logic [7:0] red_y0;
    logic [7:0] red_x1;
    logic [7:0] red_y1;
    logic [7:0] red_val;
    logic [7:0] blue_x0;
    logic [7:0] blue_y0;
    logic [7:0] blue_x1;
    logic [7:0] blue_y1;
    logic [7:0] blue_val;
    logic [7:0] background;
    logic [7:0] lower;
    logic [7:0] upper;
    logic       gaps;
} frame_row_t;

localparam int NUM_FRAMES = 7;

frame_row_t frame_table [NUM_FRAMES];

task automatic load_frame_table();
    // red rectangle on a dark background, no blue
    frame_table[0] = '{4, 2, 9, 5, 150, 255, 0, 0, 0, 0, 10, 100, 200, 1'b0};
    // blue only, red stays on the background
    frame_table[1] = '{255, 0, 0, 0, 0, 10, 8, 20, 12, 120, 10, 100, 200, 1'b0};
    // red exactly at lower, blue exactly at upper, background one below the window
    frame_table[2] = '{0, 0, 3, 0, 100, 28, 15, 31, 15, 200, 99, 100, 200, 1'b0};
    // red exactly at upper, blue exactly at lower, background one above the window
    frame_table[3] = '{5, 7, 7, 9, 200, 1, 1, 2, 2, 100, 201, 100, 200, 1'b0};
    // same picture as row 0 with random idle cycles
    frame_table[4] = '{4, 2, 9, 5, 150, 255, 0, 0, 0, 0, 10, 100, 200, 1'b1};
    // different content right after, totals must not carry over
    frame_table[5] = '{20, 10, 31, 15, 180, 0, 0, 5, 3, 110, 0, 100, 200, 1'b0};
    // whole frame red, mean lands on .5 and must round down
    frame_table[6] = '{0, 0, 31, 15, 255, 255, 0, 0, 0, 0, 0, 200, 255, 1'b1};
endtask

`endif

/* verification/tb_blob_tracker.sv */
`default_nettype none

module tb_blob_tracker;
    import blob_pkg::*;

    localparam int H_PIXELS = 32;
    localparam int V_LINES = 16;
    // eof to result_valid is about 40 cycles, leave plenty of margin
    localparam int RESULT_TIMEOUT = 200;

    logic     clk_pixel;
    logic     recent_reset;
    logic     pix_valid;
    channel_t pix_red;
    channel_t pix_blue;
    logic     pix_sof;
    logic     pix_eol;
    logic     pix_eof;
    channel_t lower_bound;
    channel_t upper_bound;
    x_coord_t blob_x;
    y_coord_t blob_y;
    count_t   red_count;
    count_t   blue_count;
    logic     blob_found;
    logic     result_valid;

    integer seed;

    // expected results of the frame under test
    int   exp_red;
    int   exp_blue;
    int   exp_x;
    int   exp_y;
    logic exp_found;

    `include "tb_frame_table.svh"

    blob_tracker_top #(
        .H_PIXELS(H_PIXELS),
        .V_LINES(V_LINES)
    ) u_dut (
        .clk_pixel(clk_pixel),
        .recent_reset(recent_reset),
        .pix_valid(pix_valid),
        .pix_red(pix_red),
        .pix_blue(pix_blue),
        .pix_sof(pix_sof),
        .pix_eol(pix_eol),
        .pix_eof(pix_eof),
        .lower_bound(lower_bound),
        .upper_bound(upper_bound),
        .blob_x(blob_x),
        .blob_y(blob_y),
        .red_count(red_count),
        .blue_count(blue_count),
        .blob_found(blob_found),
        .result_valid(result_valid)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #4 clk_pixel = ~clk_pixel;
    end

    task automatic check_value(input int frame, input string what,
                               input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t: frame %0d %s is %0d, expected %0d",
                     $time, frame, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // channel values of one pixel, straight from the row description
    function automatic logic [7:0] red_at(input frame_row_t r, input int x, input int y);
        if (x >= r.red_x0 && x <= r.red_x1 && y >= r.red_y0 && y <= r.red_y1)
            return r.red_val;
        return r.background;
    endfunction

    function automatic logic [7:0] blue_at(input frame_row_t r, input int x, input int y);
        if (x >= r.blue_x0 && x <= r.blue_x1 && y >= r.blue_y0 && y <= r.blue_y1)
            return r.blue_val;
        return r.background;
    endfunction

    // reference model: inclusive window, red sums, floor mean, zero when nothing hit
    task automatic compute_expected(input frame_row_t r);
        int sum_x;
        int sum_y;
        logic [7:0] v;
        sum_x    = 0;
        sum_y    = 0;
        exp_red  = 0;
        exp_blue = 0;
        for (int y = 0; y < V_LINES; y++) begin
            for (int x = 0; x < H_PIXELS; x++) begin
                v = red_at(r, x, y);
                if (v >= r.lower && v <= r.upper) begin
                    exp_red++;
                    sum_x += x;
                    sum_y += y;
                end
                v = blue_at(r, x, y);
                if (v >= r.lower && v <= r.upper)
                    exp_blue++;
            end
        end
        exp_x     = (exp_red == 0) ? 0 : sum_x / exp_red;
        exp_y     = (exp_red == 0) ? 0 : sum_y / exp_red;
        exp_found = exp_red != 0;
    endtask

    task automatic drive_idle();
        @(posedge clk_pixel);
        #1;
        pix_valid = 1'b0;
        pix_sof   = 1'b0;
        pix_eol   = 1'b0;
        pix_eof   = 1'b0;
    endtask

    task automatic stream_frame(input frame_row_t r);
        int gap;
        for (int y = 0; y < V_LINES; y++) begin
            for (int x = 0; x < H_PIXELS; x++) begin
                // up to three idle cycles before a pixel
                if (r.gaps) begin
                    gap = $random(seed) & 3;
                    repeat (gap) drive_idle();
                end
                @(posedge clk_pixel);
                #1;
                pix_valid = 1'b1;
                pix_red   = red_at(r, x, y);
                pix_blue  = blue_at(r, x, y);
                pix_sof   = (x == 0) && (y == 0);
                pix_eol   = (x == H_PIXELS - 1);
                pix_eof   = (x == H_PIXELS - 1) && (y == V_LINES - 1);
            end
        end
        drive_idle();
    endtask

    // result_valid is a single pulse, poll it once per cycle
    task automatic wait_for_result(input int frame);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < RESULT_TIMEOUT) begin
            @(posedge clk_pixel);
            #1;
            seen = result_valid;
            cycles++;
        end
        if (!seen) begin
            $display("frame %0d: result_valid never came within %0d cycles",
                     frame, RESULT_TIMEOUT);
            $display("Simulation FAILED");
            $fatal(1, "result timeout");
        end
    endtask

    initial begin
        seed         = 32'h7329;
        recent_reset = 1'b1;
        pix_valid    = 1'b0;
        pix_red      = '0;
        pix_blue     = '0;
        pix_sof      = 1'b0;
        pix_eol      = 1'b0;
        pix_eof      = 1'b0;
        lower_bound  = 8'd0;
        upper_bound  = 8'd255;
        repeat (5) @(posedge clk_pixel);
        #1;
        recent_reset = 1'b0;

        // quiet stream, outputs must stay at their reset values
        repeat (50) begin
            @(posedge clk_pixel);
            #1;
            check_value(-1, "result_valid", result_valid, 0);
            check_value(-1, "blob_found", blob_found, 0);
            check_value(-1, "red_count", red_count, 0);
            check_value(-1, "blue_count", blue_count, 0);
            check_value(-1, "blob_x", blob_x, 0);
            check_value(-1, "blob_y", blob_y, 0);
        end

        load_frame_table();
        for (int i = 0; i < NUM_FRAMES; i++) begin
            // window changes only between frames, with the pipeline empty
            lower_bound = frame_table[i].lower;
            upper_bound = frame_table[i].upper;
            compute_expected(frame_table[i]);
            stream_frame(frame_table[i]);
            wait_for_result(i);
            check_value(i, "red_count", red_count, exp_red);
            check_value(i, "blue_count", blue_count, exp_blue);
            check_value(i, "blob_x", blob_x, exp_x);
            check_value(i, "blob_y", blob_y, exp_y);
            check_value(i, "blob_found", blob_found, exp_found);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verification
rtl/blob_pkg.sv
rtl/pixel_position.sv
rtl/color_mask.sv
rtl/seq_divider.sv
rtl/centroid_accum.sv
rtl/blob_tracker_top.sv
verification/tb_blob_tracker.sv

/* Bender.yml */
package:
  name: blob_tracker

sources:
  # design, package first
  - rtl/blob_pkg.sv
  - rtl/pixel_position.sv
  - rtl/color_mask.sv
  - rtl/seq_divider.sv
  - rtl/centroid_accum.sv
  - rtl/blob_tracker_top.sv

  # testbench
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_blob_tracker.sv
